// ==== logic/flake_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module flake_collector (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    restart_i,
    input  frost_pkg::player_pos_t pos_i,
    output frost_pkg::score_t      score_o
);

    logic [frost_pkg::NUM_FLAKES-1:0] hit;
    logic [frost_pkg::NUM_FLAKES-1:0] fresh;
    logic [frost_pkg::NUM_FLAKES-1:0] collected_q;
    frost_pkg::score_t                fresh_cnt;
    frost_pkg::score_t                score_q;

    // strict overlap of the player box with each flake box
    for (genvar i = 0; i < frost_pkg::NUM_FLAKES; i++) begin : g_flake
        assign hit[i] =
            (pos_i.x < frost_pkg::FLAKE_X[i] + frost_pkg::FLAKE_W) &&
            (pos_i.x + frost_pkg::PLAYER_W > frost_pkg::FLAKE_X[i]) &&
            (pos_i.y < frost_pkg::FLAKE_Y[i] + frost_pkg::FLAKE_H) &&
            (pos_i.y + frost_pkg::PLAYER_H > frost_pkg::FLAKE_Y[i]);
    end

    // only flakes not taken before add to the score
    assign fresh = hit & ~collected_q;

    always_comb begin
        fresh_cnt = '0;
        for (int i = 0; i < frost_pkg::NUM_FLAKES; i++) begin
            fresh_cnt = fresh_cnt + frost_pkg::score_t'(fresh[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            collected_q <= '0;
            score_q     <= '0;
        end else begin
            collected_q <= collected_q | hit;
            score_q     <= score_q + fresh_cnt;
        end
    end

    assign score_o = score_q;

endmodule

`default_nettype wire

// ==== logic/frost_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frost_game_top #(
    parameter frost_pkg::step_cnt_t STEP_DIV    = 10'd75,
    parameter frost_pkg::step_cnt_t JUMP_START  = 10'd25,
    parameter frost_pkg::step_cnt_t JUMP_LIMIT  = 10'd50,
    parameter frost_pkg::step_cnt_t FALL_START  = 10'd50,
    parameter frost_pkg::step_cnt_t FALL_MIN    = 10'd20,
    parameter frost_pkg::step_cnt_t SPEED_STEPS = 10'd24,
    parameter frost_pkg::step_cnt_t SPEED_DELTA = 10'd5
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    tick_i,
    input  frost_pkg::key_state_t  keys_i,
    input  wire                    restart_i,
    output frost_pkg::player_pos_t pos_o,
    output logic                   airborne_o,
    output frost_pkg::score_t      score_o,
    output frost_pkg::game_state_e state_o
);

    frost_pkg::contact_t contact;
    logic [3:0]          iced_count;

    player_motion #(
        .STEP_DIV    (STEP_DIV),
        .JUMP_START  (JUMP_START),
        .JUMP_LIMIT  (JUMP_LIMIT),
        .FALL_START  (FALL_START),
        .FALL_MIN    (FALL_MIN),
        .SPEED_STEPS (SPEED_STEPS),
        .SPEED_DELTA (SPEED_DELTA)
    ) u_player_motion (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tick_i     (tick_i),
        .restart_i  (restart_i),
        .keys_i     (keys_i),
        .contact_i  (contact),
        .state_i    (state_o),
        .pos_o      (pos_o),
        .airborne_o (airborne_o)
    );

    // both observers watch the same position
    terrain_contact u_terrain_contact (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .restart_i    (restart_i),
        .pos_i        (pos_o),
        .contact_o    (contact),
        .iced_count_o (iced_count)
    );

    flake_collector u_flake_collector (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .restart_i (restart_i),
        .pos_i     (pos_o),
        .score_o   (score_o)
    );

    round_judge u_round_judge (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .restart_i    (restart_i),
        .iced_count_i (iced_count),
        .score_i      (score_o),
        .state_o      (state_o)
    );

endmodule

`default_nettype wire

// ==== logic/frost_pkg.sv ====
`default_nettype none

package frost_pkg;

    // screen coordinates and timer values
    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;
    typedef logic [9:0] step_cnt_t;
    typedef logic [3:0] score_t;

    // keys arrive already decoded, held high while pressed
    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } key_state_t;

    // which side of the player box touches terrain
    typedef struct packed {
        logic below;
        logic above;
        logic right;
        logic left;
    } contact_t;

    // top left corner of the player box
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } player_pos_t;

    typedef enum logic {
        GAME_PLAY = 1'b0,
        GAME_WIN  = 1'b1
    } game_state_e;

    // sprite boxes in pixels
    localparam int PLAYER_W   = 47;
    localparam int PLAYER_H   = 41;
    localparam int BLOCK_SIZE = 25;
    localparam int FLAKE_W    = 24;
    localparam int FLAKE_H    = 26;

    localparam int NUM_BLOCKS = 9;
    localparam int NUM_FLAKES = 4;

    // floor row of eight blocks, last entry is the wall standing on the floor
    localparam coord_x_t BLOCK_X [0:NUM_BLOCKS-1] = '{
        10'd0,   10'd25,  10'd50,  10'd75,
        10'd100, 10'd125, 10'd150, 10'd175,
        10'd200
    };
    localparam coord_y_t BLOCK_Y [0:NUM_BLOCKS-1] = '{
        9'd400, 9'd400, 9'd400, 9'd400,
        9'd400, 9'd400, 9'd400, 9'd400,
        9'd375
    };

    // flakes hover just above the floor
    localparam coord_x_t FLAKE_X [0:NUM_FLAKES-1] = '{
        10'd60, 10'd90, 10'd120, 10'd170
    };
    localparam coord_y_t FLAKE_Y [0:NUM_FLAKES-1] = '{
        9'd370, 9'd370, 9'd370, 9'd370
    };

    // bottom edge 359 + 41 lands exactly on the floor top
    localparam coord_x_t SPAWN_X = 10'd0;
    localparam coord_y_t SPAWN_Y = 9'd359;

endpackage

`default_nettype wire

// ==== logic/player_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_motion #(
    parameter frost_pkg::step_cnt_t STEP_DIV    = 10'd75,
    parameter frost_pkg::step_cnt_t JUMP_START  = 10'd25,
    parameter frost_pkg::step_cnt_t JUMP_LIMIT  = 10'd50,
    parameter frost_pkg::step_cnt_t FALL_START  = 10'd50,
    parameter frost_pkg::step_cnt_t FALL_MIN    = 10'd20,
    parameter frost_pkg::step_cnt_t SPEED_STEPS = 10'd24,
    parameter frost_pkg::step_cnt_t SPEED_DELTA = 10'd5
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    tick_i,
    input  wire                    restart_i,
    input  frost_pkg::key_state_t  keys_i,
    input  frost_pkg::contact_t    contact_i,
    input  frost_pkg::game_state_e state_i,
    output frost_pkg::player_pos_t pos_o,
    output logic                   airborne_o
);

    typedef enum logic [1:0] {
        v_ground,
        v_jump,
        v_fall
    } vert_state_e;

    vert_state_e           v_state;
    frost_pkg::coord_x_t   x_q;
    frost_pkg::coord_y_t   y_q;
    frost_pkg::step_cnt_t  left_div;
    frost_pkg::step_cnt_t  right_div;
    frost_pkg::step_cnt_t  pix_div;
    frost_pkg::step_cnt_t  speed_cnt;
    frost_pkg::step_cnt_t  jump_timer;
    frost_pkg::step_cnt_t  fall_timer;
    logic                  move_en;
    logic                  go_left;
    logic                  go_right;

    // nothing moves between ticks or once the round is won
    assign move_en  = tick_i && (state_i == frost_pkg::GAME_PLAY);

    // opposite keys cancel, x = 0 is the screen edge
    assign go_left  = keys_i.left && !keys_i.right && !contact_i.left && (x_q != '0);
    assign go_right = keys_i.right && !keys_i.left && !contact_i.right;

    // horizontal walk, one pixel every STEP_DIV+1 ticks
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            x_q       <= frost_pkg::SPAWN_X;
            left_div  <= '0;
            right_div <= '0;
        end else if (move_en) begin
            if (go_left) begin
                right_div <= '0;
                if (left_div < STEP_DIV) begin
                    left_div <= left_div + 1'b1;
                end else begin
                    left_div <= '0;
                    x_q      <= x_q - 1'b1;
                end
            end else if (go_right) begin
                left_div <= '0;
                if (right_div < STEP_DIV) begin
                    right_div <= right_div + 1'b1;
                end else begin
                    right_div <= '0;
                    x_q       <= x_q + 1'b1;
                end
            end else begin
                left_div  <= '0;
                right_div <= '0;
            end
        end
    end

    // vertical FSM, a larger timer means a slower pixel step
    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            v_state    <= v_ground;
            y_q        <= frost_pkg::SPAWN_Y;
            pix_div    <= '0;
            speed_cnt  <= '0;
            jump_timer <= JUMP_START;
            fall_timer <= FALL_START;
        end else if (move_en) begin
            case (v_state)
                v_ground: begin
                    pix_div    <= '0;
                    speed_cnt  <= '0;
                    jump_timer <= JUMP_START;
                    fall_timer <= FALL_START;
                    if (!contact_i.below) begin
                        v_state <= v_fall;
                    end else if (keys_i.jump) begin
                        v_state <= v_jump;
                    end
                end
                v_jump: begin
                    if (contact_i.above || (jump_timer >= JUMP_LIMIT)) begin
                        v_state    <= v_fall;
                        pix_div    <= '0;
                        speed_cnt  <= '0;
                        fall_timer <= FALL_START;
                    end else if (speed_cnt == SPEED_STEPS) begin
                        // rise slows down
                        speed_cnt  <= '0;
                        jump_timer <= jump_timer + SPEED_DELTA;
                    end else if (pix_div < jump_timer) begin
                        pix_div <= pix_div + 1'b1;
                    end else begin
                        pix_div   <= '0;
                        speed_cnt <= speed_cnt + 1'b1;
                        y_q       <= y_q - 1'b1;
                    end
                end
                v_fall: begin
                    if (contact_i.below) begin
                        v_state <= v_ground;
                        pix_div <= '0;
                    end else if (speed_cnt == SPEED_STEPS) begin
                        // fall speeds up until the cap
                        speed_cnt <= '0;
                        if (fall_timer >= FALL_MIN + SPEED_DELTA) begin
                            fall_timer <= fall_timer - SPEED_DELTA;
                        end else begin
                            fall_timer <= FALL_MIN;
                        end
                    end else if (pix_div < fall_timer) begin
                        pix_div <= pix_div + 1'b1;
                    end else begin
                        pix_div   <= '0;
                        speed_cnt <= speed_cnt + 1'b1;
                        y_q       <= y_q + 1'b1;
                    end
                end
                default: begin
                    v_state <= v_ground;
                end
            endcase
        end
    end

    assign pos_o.x    = x_q;
    assign pos_o.y    = y_q;
    assign airborne_o = ~contact_i.below;

endmodule

`default_nettype wire

// ==== logic/round_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_judge (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    restart_i,
    input  wire [3:0]              iced_count_i,
    input  frost_pkg::score_t      score_i,
    output frost_pkg::game_state_e state_o
);

    frost_pkg::game_state_e state_q;
    logic                   all_done;

    // every block iced and every flake taken
    assign all_done = (iced_count_i == 4'(frost_pkg::NUM_BLOCKS)) &&
                      (score_i == frost_pkg::score_t'(frost_pkg::NUM_FLAKES));

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            state_q <= frost_pkg::GAME_PLAY;
        end else begin
            case (state_q)
                frost_pkg::GAME_PLAY: begin
                    if (all_done) begin
                        state_q <= frost_pkg::GAME_WIN;
                    end
                end
                // a won round waits for restart
                frost_pkg::GAME_WIN: begin
                    state_q <= frost_pkg::GAME_WIN;
                end
                default: begin
                    state_q <= frost_pkg::GAME_PLAY;
                end
            endcase
        end
    end

    assign state_o = state_q;

endmodule

`default_nettype wire

// ==== logic/terrain_contact.sv ====
`timescale 1ns/1ps
`default_nettype none

module terrain_contact (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    restart_i,
    input  frost_pkg::player_pos_t pos_i,
    output frost_pkg::contact_t    contact_o,
    output logic [3:0]             iced_count_o
);

    frost_pkg::player_pos_t              probe;
    logic [frost_pkg::NUM_BLOCKS-1:0]    hit_below;
    logic [frost_pkg::NUM_BLOCKS-1:0]    hit_above;
    logic [frost_pkg::NUM_BLOCKS-1:0]    hit_right;
    logic [frost_pkg::NUM_BLOCKS-1:0]    hit_left;
    logic [frost_pkg::NUM_BLOCKS-1:0]    iced_q;
    frost_pkg::contact_t                 flags;
    frost_pkg::contact_t                 contact_q;

    // during reset the spawn point is tested, so the player comes up standing
    always_comb begin
        probe = pos_i;
        if (!rst_n_i || restart_i) begin
            probe.x = frost_pkg::SPAWN_X;
            probe.y = frost_pkg::SPAWN_Y;
        end
    end

    for (genvar i = 0; i < frost_pkg::NUM_BLOCKS; i++) begin : g_block
        logic h_ovl;
        logic v_ovl;

        // box edges are exclusive, touching edges do not overlap
        assign h_ovl = (probe.x < frost_pkg::BLOCK_X[i] + frost_pkg::BLOCK_SIZE) &&
                       (probe.x + frost_pkg::PLAYER_W > frost_pkg::BLOCK_X[i]);
        assign v_ovl = (probe.y < frost_pkg::BLOCK_Y[i] + frost_pkg::BLOCK_SIZE) &&
                       (probe.y + frost_pkg::PLAYER_H > frost_pkg::BLOCK_Y[i]);

        assign hit_below[i] = h_ovl &&
            (probe.y + frost_pkg::PLAYER_H == frost_pkg::BLOCK_Y[i]);
        assign hit_above[i] = h_ovl &&
            (probe.y == frost_pkg::BLOCK_Y[i] + frost_pkg::BLOCK_SIZE);
        assign hit_right[i] = v_ovl &&
            (probe.x + frost_pkg::PLAYER_W == frost_pkg::BLOCK_X[i]);
        assign hit_left[i]  = v_ovl &&
            (probe.x == frost_pkg::BLOCK_X[i] + frost_pkg::BLOCK_SIZE);
    end

    assign flags.below = |hit_below;
    assign flags.above = |hit_above;
    assign flags.right = |hit_right;
    assign flags.left  = |hit_left;

    always_ff @(posedge clk) begin
        contact_q <= flags;
        if (!rst_n_i || restart_i) begin
            iced_q <= '0;
        end else begin
            // a touched block stays iced for the rest of the round
            iced_q <= iced_q | hit_below | hit_above | hit_right | hit_left;
        end
    end

    // population count of the iced mask
    always_comb begin
        iced_count_o = '0;
        for (int i = 0; i < frost_pkg::NUM_BLOCKS; i++) begin
            iced_count_o = iced_count_o + 4'(iced_q[i]);
        end
    end

    assign contact_o = contact_q;

endmodule

`default_nettype wire

// ==== project.f ====
logic/frost_pkg.sv
logic/player_motion.sv
logic/terrain_contact.sv
logic/flake_collector.sv
logic/round_judge.sv
logic/frost_game_top.sv
verif/frost_game_chk.sv
verif/frost_game_tb.sv

// ==== verif/frost_game_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module frost_game_chk (
    input wire                    clk,
    input wire                    rst_n_i,
    input wire                    tick_i,
    input wire                    restart_i,
    input frost_pkg::player_pos_t pos_i,
    input frost_pkg::score_t      score_i,
    input frost_pkg::game_state_e state_i
);

    logic running;
    int   fail_count = 0;

    // reset and restart may move the player at any time
    assign running = rst_n_i && !restart_i;

    // one point per flake at most
    score_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        score_i <= frost_pkg::score_t'(frost_pkg::NUM_FLAKES))
        else begin
            $error("score is above the number of flakes");
            fail_count++;
        end

    pos_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (running && !tick_i) |=> $stable(pos_i))
        else begin
            $error("player moved on a cycle without a movement tick");
            fail_count++;
        end

    pos_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
        (running && state_i == frost_pkg::GAME_WIN) |=> $stable(pos_i))
        else begin
            $error("player moved after the round was won");
            fail_count++;
        end

    // a won round has every flake collected
    win_score: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_i == frost_pkg::GAME_WIN) |->
            (score_i == frost_pkg::score_t'(frost_pkg::NUM_FLAKES)))
        else begin
            $error("round won with flakes left");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verif/frost_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frost_game_tb;

    localparam int STEP_DIV    = 1;
    localparam int JUMP_START  = 25;
    localparam int JUMP_LIMIT  = 50;
    localparam int FALL_START  = 50;
    localparam int FALL_MIN    = 20;
    localparam int SPEED_STEPS = 24;
    localparam int SPEED_DELTA = 5;
    localparam int STEP_TICKS  = STEP_DIV + 1;
    localparam int NUM_ROWS    = 9;
    // rise and fall each stay well inside half of this many ticks
    localparam int JUMP_BOUND  = 2 * (JUMP_LIMIT / SPEED_DELTA) * SPEED_STEPS * (JUMP_LIMIT + 2);

    // key bits are left, right, jump from msb down
    localparam frost_pkg::key_state_t KEY_NONE  = 3'b000;
    localparam frost_pkg::key_state_t KEY_LEFT  = 3'b100;
    localparam frost_pkg::key_state_t KEY_RIGHT = 3'b010;
    localparam frost_pkg::key_state_t KEY_JUMP  = 3'b001;

    typedef struct packed {
        frost_pkg::key_state_t  keys;
        logic                   restart;
        logic                   jump;
        logic [15:0]            cycles;
        logic                   settle;
        frost_pkg::coord_x_t    exp_x;
        frost_pkg::score_t      exp_score;
        frost_pkg::game_state_e exp_state;
    } row_t;

    logic                   clk;
    logic                   rst_n_i;
    logic                   tick_i;
    logic                   restart_i;
    frost_pkg::key_state_t  keys_i;
    frost_pkg::player_pos_t pos_o;
    logic                   airborne_o;
    frost_pkg::score_t      score_o;
    frost_pkg::game_state_e state_o;

    row_t        rows [0:NUM_ROWS-1];
    string       row_names [0:NUM_ROWS-1];
    int          row_cnt;
    int          ref_x;
    int          ref_peak;
    logic        ref_win;
    int          wall_stop;
    int          watchdog_cycles;
    logic        table_built;
    logic [31:0] rng_state;
    int          pos_errors;
    int          score_errors;
    int          state_errors;
    int          flag_errors;
    int          other_errors;

    frost_game_top #(
        .STEP_DIV    (STEP_DIV),
        .JUMP_START  (JUMP_START),
        .JUMP_LIMIT  (JUMP_LIMIT),
        .FALL_START  (FALL_START),
        .FALL_MIN    (FALL_MIN),
        .SPEED_STEPS (SPEED_STEPS),
        .SPEED_DELTA (SPEED_DELTA)
    ) uut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tick_i     (tick_i),
        .keys_i     (keys_i),
        .restart_i  (restart_i),
        .pos_o      (pos_o),
        .airborne_o (airborne_o),
        .score_o    (score_o),
        .state_o    (state_o)
    );

    bind frost_game_top frost_game_chk u_chk (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tick_i    (tick_i),
        .restart_i (restart_i),
        .pos_i     (pos_o),
        .score_i   (score_o),
        .state_i   (state_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_pos(input string name, input frost_pkg::player_pos_t exp,
                             input frost_pkg::player_pos_t act, input int tol);
        int dx;
        dx = int'(act.x) - int'(exp.x);
        if ($isunknown(act) || dx < -tol || dx > tol || act.y !== exp.y) begin
            pos_errors++;
            $display("[FAIL] %s: pos expected x=%0d y=%0d, actual x=%0d y=%0d",
                     name, exp.x, exp.y, act.x, act.y);
        end
    endtask

    task automatic check_score(input string name, input frost_pkg::score_t exp,
                               input frost_pkg::score_t act);
        if (act !== exp) begin
            score_errors++;
            $display("[FAIL] %s: score expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input frost_pkg::game_state_e exp,
                               input frost_pkg::game_state_e act);
        if (act !== exp) begin
            state_errors++;
            $display("[FAIL] %s: state expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_airborne(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("[FAIL] %s: airborne expected %b, actual %b", name, exp, act);
        end
    endtask

    // reference rules, applied row by row to fill in the expected values
    task automatic add_row(input string name, input frost_pkg::key_state_t keys,
                           input logic restart, input logic jump, input int cycles);
        row_t r;
        int   steps;
        int   count;
        steps    = cycles / STEP_TICKS;
        r.keys    = keys;
        r.restart = restart;
        r.jump    = jump;
        r.cycles  = 16'(cycles);
        r.settle  = 1'b0;
        if (restart) begin
            ref_x    = frost_pkg::SPAWN_X;
            ref_peak = ref_x;
            ref_win  = 1'b0;
        end else if (!ref_win && !jump) begin
            if (keys.right && !keys.left) begin
                ref_x    = (ref_x + steps < wall_stop) ? ref_x + steps : wall_stop;
                r.settle = (ref_x != wall_stop);
            end else if (keys.left && !keys.right) begin
                ref_x    = (ref_x > steps) ? ref_x - steps : 0;
                r.settle = (ref_x != 0);
            end
        end
        if (ref_x > ref_peak) begin
            ref_peak = ref_x;
        end
        // reaching the wall from spawn touches every floor block and the wall
        if (ref_x == wall_stop) begin
            ref_win = 1'b1;
        end
        count = 0;
        for (int i = 0; i < frost_pkg::NUM_FLAKES; i++) begin
            if (int'(frost_pkg::FLAKE_X[i]) < ref_peak + frost_pkg::PLAYER_W) begin
                count++;
            end
        end
        r.exp_x     = frost_pkg::coord_x_t'(ref_x);
        r.exp_score = frost_pkg::score_t'(count);
        r.exp_state = ref_win ? frost_pkg::GAME_WIN : frost_pkg::GAME_PLAY;
        rows[row_cnt]      = r;
        row_names[row_cnt] = name;
        row_cnt++;
        watchdog_cycles += cycles + 2 + (jump ? JUMP_BOUND + 64 : 0);
    endtask

    task automatic build_table();
        // the wall is the last block, the player stops with its right edge on it
        wall_stop = int'(frost_pkg::BLOCK_X[frost_pkg::NUM_BLOCKS-1]) - frost_pkg::PLAYER_W;
        ref_x     = frost_pkg::SPAWN_X;
        ref_peak  = ref_x;
        ref_win   = 1'b0;
        add_row("after_reset", KEY_NONE, 1'b0, 1'b0, 4);
        add_row("walk_right_a", KEY_RIGHT, 1'b0, 1'b0, 60);
        add_row("walk_right_b", KEY_RIGHT, 1'b0, 1'b0, 40);
        add_row("walk_left", KEY_LEFT, 1'b0, 1'b0, 30);
        add_row("jump", KEY_JUMP, 1'b0, 1'b1, 0);
        add_row("walk_to_wall", KEY_RIGHT, 1'b0, 1'b0, 300);
        add_row("keys_after_win", KEY_LEFT, 1'b0, 1'b0, 20);
        add_row("restart", KEY_NONE, 1'b1, 1'b0, 1);
        add_row("walk_after_restart", KEY_RIGHT, 1'b0, 1'b0, 100);
    endtask

    // called on a rising edge, returns once the player stands on the floor again
    task automatic run_jump(input string name);
        int                  hold;
        int                  n;
        logic                seen_air;
        logic                landed;
        frost_pkg::coord_y_t top_y;
        rng_state = next_random(rng_state);
        hold      = 1 + int'(rng_state % 32);
        keys_i <= KEY_JUMP;
        repeat (hold) @(posedge clk);
        keys_i <= KEY_NONE;
        seen_air = 1'b0;
        landed   = 1'b0;
        top_y    = frost_pkg::SPAWN_Y;
        n        = 0;
        while (!landed && n < JUMP_BOUND) begin
            @(negedge clk);
            if (airborne_o === 1'b1) begin
                seen_air = 1'b1;
            end
            if (pos_o.y < top_y) begin
                top_y = pos_o.y;
            end
            landed = seen_air && (airborne_o === 1'b0) && (pos_o.y == frost_pkg::SPAWN_Y);
            n++;
        end
        if (!seen_air || top_y >= frost_pkg::SPAWN_Y) begin
            other_errors++;
            $display("ERROR: %s: the player never left the floor", name);
        end else if (!landed) begin
            other_errors++;
            $display("ERROR: %s: the player did not land within %0d ticks", name, JUMP_BOUND);
        end
        check_airborne(name, 1'b0, airborne_o);
    endtask

    task automatic run_row(input int n);
        row_t                   r;
        frost_pkg::player_pos_t exp_pos;
        r         = rows[n];
        exp_pos.x = r.exp_x;
        exp_pos.y = frost_pkg::SPAWN_Y;
        @(posedge clk);
        restart_i <= r.restart;
        if (r.jump) begin
            run_jump(row_names[n]);
        end else begin
            keys_i <= r.keys;
            repeat (int'(r.cycles)) @(posedge clk);
            // keys and restart are let go on the last edge of the row
            keys_i    <= KEY_NONE;
            restart_i <= 1'b0;
            @(negedge clk);
            check_airborne(row_names[n], 1'b0, airborne_o);
        end
        check_pos(row_names[n], exp_pos, pos_o, r.settle ? 1 : 0);
        check_score(row_names[n], r.exp_score, score_o);
        check_state(row_names[n], r.exp_state, state_o);
    endtask

    initial begin
        wait (table_built);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: simulation timed out after %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n_i         = 1'b0;
        tick_i          = 1'b1;
        restart_i       = 1'b0;
        keys_i          = KEY_NONE;
        rng_state       = 32'd15775;
        row_cnt         = 0;
        watchdog_cycles = 100;
        table_built     = 1'b0;
        pos_errors      = 0;
        score_errors    = 0;
        state_errors    = 0;
        flag_errors     = 0;
        other_errors    = 0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int n = 0; n < row_cnt; n++) begin
            run_row(n);
        end
        $display("errors: pos=%0d score=%0d state=%0d airborne=%0d other=%0d assertions=%0d",
                 pos_errors, score_errors, state_errors, flag_errors, other_errors,
                 uut.u_chk.fail_count);
        if (pos_errors + score_errors + state_errors + flag_errors + other_errors +
            uut.u_chk.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
